/* Makefile */
# Verilator build and run of the block quantizer testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -sv -f list.f \
		--top-module quant_tb -o quant_sim
	./obj_dir/quant_sim | tee $(LOG)
	@if grep -qx "=== PASS ===" $(LOG); then \
		echo "Result: passed"; \
	else \
		echo "Result: failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* design/quant_block.sv */
//--------------------------------------
// Quantizer core for one 4x4 block
// Stage 1 scales each coefficient by the inverse step
// Stage 2 saturates, dequantizes and scans to zigzag
//--------------------------------------
`timescale 1ns/1ns

module quant_block (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_i,
    input  quant_data_pkg::coef_block_t block_i,
    input  quant_cfg_pkg::matrix_t      matrix_i,
    output logic                        done_o,
    output quant_data_pkg::quant_res_t  res_o
);

    localparam int PW = 40;
    localparam int LW = PW - quant_cfg_pkg::QFIX;

    // Per-coefficient stage 1 record
    typedef struct packed {
        logic [LW-1:0] level;
        logic          sign;
        logic          above;
        logic [15:0]   q;
    } s1_t;

    logic                        s1_vld;
    quant_data_pkg::coef_block_t lvl_raster;
    quant_data_pkg::coef_block_t recon_d;
    logic [quant_cfg_pkg::NUM_COEF-1:0] nz_bits;

    for (genvar k = 0; k < quant_cfg_pkg::NUM_COEF; k++) begin : g_coef
        quant_data_pkg::coef_t c;
        logic [16:0]           mag;
        logic [31:0]           coeff;
        logic [PW-1:0]         scaled;
        s1_t                   s1_q;
        logic [LW-1:0]         sat;
        quant_data_pkg::coef_t lvl;
        logic signed [32:0]    prod;

        //--------------------------------------
        // Stage 1
        //--------------------------------------
        assign c   = block_i[k];
        // 17 bits so that -32768 has a magnitude
        assign mag = c[15] ? (17'd0 - {c[15], c}) : {1'b0, c};
        assign coeff  = 32'(mag) + 32'(matrix_i[k].sharpen);
        assign scaled = PW'(coeff) * PW'(matrix_i[k].iq) + PW'(matrix_i[k].bias);

        always_ff @(posedge clk) begin
            if (start_i) begin
                s1_q.level <= LW'(scaled >> quant_cfg_pkg::QFIX);
                s1_q.sign  <= c[15];
                s1_q.above <= coeff > matrix_i[k].zthresh;
                s1_q.q     <= matrix_i[k].q;
            end
        end

        //--------------------------------------
        // Stage 2
        //--------------------------------------
        assign sat = (s1_q.level > LW'(quant_cfg_pkg::MAX_LEVEL)) ?
                     LW'(quant_cfg_pkg::MAX_LEVEL) : s1_q.level;
        assign lvl = !s1_q.above ? '0 :
                     s1_q.sign   ? -$signed(sat[15:0]) : $signed(sat[15:0]);
        assign prod = lvl * $signed({1'b0, s1_q.q});

        // Recon keeps the low 16 bits of the product
        assign lvl_raster[k] = lvl;
        assign recon_d[k]    = prod[15:0];
        assign nz_bits[k]    = |lvl;
    end

    // Valid pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld <= 1'b0;
            done_o <= 1'b0;
        end else begin
            s1_vld <= start_i;
            done_o <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_vld) begin
            for (int k = 0; k < quant_cfg_pkg::NUM_COEF; k++) begin
                res_o.levels[k] <= lvl_raster[quant_data_pkg::ZIGZAG[k]];
            end
            res_o.recon <= recon_d;
            res_o.nz    <= |nz_bits;
        end
    end

endmodule

/* design/quant_cfg_pkg.sv */
//--------------------------------------
// Quantizer configuration package
// Fixed-point constants, block type, per-coefficient matrix entry
// and the base step tables behind the matrix ROM
//--------------------------------------
package quant_cfg_pkg;

    localparam int QFIX      = 17;
    localparam int MAX_LEVEL = 2047;
    localparam int NUM_COEF  = 16;

    typedef enum logic {
        BT_LUMA   = 1'b0,
        BT_CHROMA = 1'b1
    } block_type_e;

    // Constants for one coefficient position
    typedef struct packed {
        logic [15:0] q;
        logic [15:0] iq;
        logic [31:0] bias;
        logic [31:0] zthresh;
        logic [15:0] sharpen;
    } matrix_entry_t;

    typedef matrix_entry_t [NUM_COEF-1:0] matrix_t;

    // Base steps per quantizer index
    localparam int unsigned DC_BASE_Q [0:7] = '{8, 12, 18, 26, 36, 50, 68, 91};
    localparam int unsigned AC_BASE_Q [0:7] = '{8, 14, 22, 32, 46, 64, 88, 120};

    localparam int unsigned BIAS_LUMA_DC   = 96;
    localparam int unsigned BIAS_LUMA_AC   = 110;
    localparam int unsigned BIAS_CHROMA_DC = 110;
    localparam int unsigned BIAS_CHROMA_AC = 115;

    // Frequency weights for luma sharpening, raster order
    localparam int unsigned SHARPEN_TAB [0:15] = '{0, 30, 60, 90, 30, 60, 90, 90,
                                                   60, 90, 90, 90, 90, 90, 90, 90};

endpackage

/* design/quant_ctrl.sv */
//--------------------------------------
// Quantizer control
// Runs the four-phase input and output links, holds the request
// and the result, one block outstanding at a time
//--------------------------------------
`timescale 1ns/1ns

module quant_ctrl #(
    parameter int NUM_QIDX = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_req_i,
    input  quant_data_pkg::quant_req_t  in_data_i,
    output logic                        in_ack_o,
    output logic                        out_req_o,
    output quant_data_pkg::quant_res_t  out_data_o,
    input  logic                        out_ack_i,
    output logic [2:0]                  qidx_o,
    output quant_cfg_pkg::block_type_e  btype_o,
    output logic                        start_o,
    output quant_data_pkg::coef_block_t block_o,
    input  logic                        done_i,
    input  quant_data_pkg::quant_res_t  res_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CAPTURE,
        ST_CORE,
        ST_OFFER,
        ST_RELEASE
    } state_e;

    state_e                     state;
    quant_data_pkg::quant_req_t req_q;
    logic                       accept;

    // New request only once the previous ack has dropped
    assign accept = (state == ST_IDLE) && in_req_i && !in_ack_o;

    // Request hold, index clamped to the table depth
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.blk   <= in_data_i.blk;
            req_q.btype <= in_data_i.btype;
            req_q.qidx  <= (int'(in_data_i.qidx) >= NUM_QIDX) ?
                           3'(NUM_QIDX - 1) : in_data_i.qidx;
        end
    end

    //--------------------------------------
    // Handshake FSM
    //--------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            in_ack_o   <= 1'b0;
            out_req_o  <= 1'b0;
            start_o    <= 1'b0;
            out_data_o <= '0;
        end else begin
            start_o <= 1'b0;
            if (in_ack_o && !in_req_i) begin
                in_ack_o <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        in_ack_o <= 1'b1;
                        state    <= ST_CAPTURE;
                    end
                end
                ST_CAPTURE: begin
                    start_o <= 1'b1;
                    state   <= ST_CORE;
                end
                ST_CORE: begin
                    if (done_i) begin
                        out_data_o <= res_i;
                        out_req_o  <= 1'b1;
                        state      <= ST_OFFER;
                    end
                end
                ST_OFFER: begin
                    if (out_ack_i) begin
                        out_req_o <= 1'b0;
                        state     <= ST_RELEASE;
                    end
                end
                // Wait for the receiver to drop ack
                ST_RELEASE: begin
                    if (!out_ack_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign qidx_o  = req_q.qidx;
    assign btype_o = req_q.btype;
    assign block_o = req_q.blk;

endmodule

/* design/quant_data_pkg.sv */
//--------------------------------------
// Quantizer data package
// Coefficient block, request and result records, zigzag scan order
//--------------------------------------
package quant_data_pkg;

    typedef logic signed [15:0] coef_t;

    // Raster order unless stated otherwise
    typedef coef_t [quant_cfg_pkg::NUM_COEF-1:0] coef_block_t;

    typedef struct packed {
        coef_block_t               blk;
        logic [2:0]                qidx;
        quant_cfg_pkg::block_type_e btype;
    } quant_req_t;

    typedef struct packed {
        // Zigzag order
        coef_block_t levels;
        // Raster order
        coef_block_t recon;
        logic        nz;
    } quant_res_t;

    // Raster position of each zigzag slot
    localparam int unsigned ZIGZAG [0:15] = '{0, 1, 4, 8, 5, 2, 3, 6,
                                              9, 12, 13, 10, 7, 11, 14, 15};

endpackage

/* design/quant_matrix_rom.sv */
//--------------------------------------
// Quantizer matrix ROM
// Builds every matrix at elaboration from the base steps
// and reads one out combinationally by index and block type
//--------------------------------------
`timescale 1ns/1ns

module quant_matrix_rom #(
    parameter int NUM_QIDX = 8
) (
    input  logic [2:0]                 qidx_i,
    input  quant_cfg_pkg::block_type_e btype_i,
    output quant_cfg_pkg::matrix_t     matrix_o
);

    // One whole matrix for a given index and type
    function automatic quant_cfg_pkg::matrix_t make_matrix(input int qi, input int bt);
        quant_cfg_pkg::matrix_t m;
        int unsigned q;
        int unsigned b;
        int unsigned iq;
        for (int k = 0; k < quant_cfg_pkg::NUM_COEF; k++) begin
            q = (k == 0) ? quant_cfg_pkg::DC_BASE_Q[qi] : quant_cfg_pkg::AC_BASE_Q[qi];
            if (bt == int'(quant_cfg_pkg::BT_CHROMA)) begin
                // Chroma runs at half step, floor of 2
                q = q / 2;
                if (q < 2) begin
                    q = 2;
                end
                b = (k == 0) ? quant_cfg_pkg::BIAS_CHROMA_DC : quant_cfg_pkg::BIAS_CHROMA_AC;
            end else begin
                b = (k == 0) ? quant_cfg_pkg::BIAS_LUMA_DC : quant_cfg_pkg::BIAS_LUMA_AC;
            end
            iq = 131072 / q;
            b  = b << 9;
            m[k].q       = 16'(q);
            m[k].iq      = 16'(iq);
            m[k].bias    = 32'(b);
            m[k].zthresh = 32'((131071 - b) / iq);
            if (bt == int'(quant_cfg_pkg::BT_LUMA) && k != 0) begin
                m[k].sharpen = 16'((quant_cfg_pkg::SHARPEN_TAB[k] * q) >> 11);
            end else begin
                m[k].sharpen = '0;
            end
        end
        return m;
    endfunction

    quant_cfg_pkg::matrix_t table_q [0:1][0:NUM_QIDX-1];

    //--------------------------------------
    // Constant table
    //--------------------------------------
    for (genvar t = 0; t < 2; t++) begin : g_type
        for (genvar i = 0; i < NUM_QIDX; i++) begin : g_qidx
            localparam quant_cfg_pkg::matrix_t ENTRY = make_matrix(i, t);
            assign table_q[t][i] = ENTRY;
        end
    end

    // Index is already clamped to the table depth upstream
    assign matrix_o = table_q[btype_i][qidx_i];

endmodule

/* design/quant_top.sv */
//--------------------------------------
// Block quantizer top level
// Control, matrix ROM and quantizer core
//--------------------------------------
`timescale 1ns/1ns

module quant_top #(
    parameter int NUM_QIDX = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_req_i,
    input  quant_data_pkg::quant_req_t in_data_i,
    output logic                       in_ack_o,
    output logic                       out_req_o,
    output quant_data_pkg::quant_res_t out_data_o,
    input  logic                       out_ack_i
);

    logic [2:0]                  qidx;
    quant_cfg_pkg::block_type_e  btype;
    quant_cfg_pkg::matrix_t      matrix;
    logic                        start;
    quant_data_pkg::coef_block_t block;
    logic                        done;
    quant_data_pkg::quant_res_t  res;

    quant_ctrl #(
        .NUM_QIDX (NUM_QIDX)
    ) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req_i   (in_req_i),
        .in_data_i  (in_data_i),
        .in_ack_o   (in_ack_o),
        .out_req_o  (out_req_o),
        .out_data_o (out_data_o),
        .out_ack_i  (out_ack_i),
        .qidx_o     (qidx),
        .btype_o    (btype),
        .start_o    (start),
        .block_o    (block),
        .done_i     (done),
        .res_i      (res)
    );

    quant_matrix_rom #(
        .NUM_QIDX (NUM_QIDX)
    ) u_rom (
        .qidx_i   (qidx),
        .btype_i  (btype),
        .matrix_o (matrix)
    );

    quant_block u_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (start),
        .block_i  (block),
        .matrix_i (matrix),
        .done_o   (done),
        .res_o    (res)
    );

endmodule

/* list.f */
design/quant_cfg_pkg.sv
design/quant_data_pkg.sv
design/quant_matrix_rom.sv
design/quant_block.sv
design/quant_ctrl.sv
design/quant_top.sv
tb/quant_clk_gen.sv
tb/quant_assert.sv
tb/quant_tb.sv

/* tb/quant_assert.sv */
//--------------------------------------
// Handshake assertions for quant_ctrl
// Four-phase rules on both links and the start pulse
//--------------------------------------
`timescale 1ns/1ns

module quant_assert (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       in_req_i,
    input logic                       in_ack_i,
    input logic                       out_req_i,
    input logic                       out_ack_i,
    input logic                       start_i,
    input quant_data_pkg::quant_res_t out_data_i
);

    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack_i) |-> in_req_i)
        else $error("in_ack rose while in_req was low");

    // Offer stays up until the receiver answers
    req_holds: assert property (@(posedge clk) disable iff (!rst_n)
        out_req_i && !out_ack_i |=> out_req_i)
        else $error("out_req dropped before out_ack");

    data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_req_i && $past(out_req_i) |-> $stable(out_data_i))
        else $error("out_data changed while out_req was high");

    start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |=> !start_i)
        else $error("start held high for more than one cycle");

endmodule

bind quant_ctrl quant_assert u_hs_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_req_i   (in_req_i),
    .in_ack_i   (in_ack_o),
    .out_req_i  (out_req_o),
    .out_ack_i  (out_ack_i),
    .start_i    (start_o),
    .out_data_i (out_data_o)
);

/* tb/quant_clk_gen.sv */
//--------------------------------------
// Testbench clock and reset source
//--------------------------------------
`timescale 1ns/1ns

module quant_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Reset held low for a fixed number of cycles
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* tb/quant_tb.sv */
//--------------------------------------
// Block quantizer testbench
// Directed and random 4x4 blocks over both four-phase links
// Results checked against a model of the quantizer rules
//--------------------------------------
`timescale 1ns/1ns

module quant_tb;

    localparam int RAND_PER_CASE    = 2;
    localparam int NUM_BLOCKS       = 1 + 16 * RAND_PER_CASE + 4 + 8;
    localparam int CYCLES_PER_BLOCK = 200;

    // 32767, -32767, 32766, -32768
    localparam logic [15:0] NEAR_FULL [0:3] = '{16'h7FFF, 16'h8001, 16'h7FFE, 16'h8000};

    logic                       clk;
    logic                       rst_n;
    logic                       in_req;
    quant_data_pkg::quant_req_t in_data;
    logic                       in_ack;
    logic                       out_req;
    quant_data_pkg::quant_res_t out_data;
    logic                       out_ack;

    // Expected results in request order
    quant_data_pkg::quant_res_t exp_q [$];
    int                         n_checked = 0;
    logic [15:0]                drv_lfsr  = 16'd19;
    logic [15:0]                ack_lfsr  = 16'd19;

    quant_clk_gen #(
        .PERIOD     (20),
        .RST_CYCLES (10)
    ) u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    quant_top #(
        .NUM_QIDX (8)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req_i   (in_req),
        .in_data_i  (in_data),
        .in_ack_o   (in_ack),
        .out_req_o  (out_req),
        .out_data_o (out_data),
        .out_ack_i  (out_ack)
    );

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    // Galois LFSR with taps 0xB400 stepped once per bit taken
    function automatic int unsigned lfsr_bits(inout logic [15:0] state, input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v     = (v << 1) | int'(state[0]);
            state = (state >> 1) ^ (state[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    //--------------------------------------
    // Reference model
    //--------------------------------------
    function automatic quant_data_pkg::quant_res_t ref_quant(
        input quant_data_pkg::quant_req_t r
    );
        quant_data_pkg::quant_res_t  res;
        quant_data_pkg::coef_block_t lv;
        int                          q;
        int                          bias;
        int                          iq;
        int                          zth;
        int                          shp;
        int                          v;
        int                          coeff;
        int                          lvl;
        longint                      scaled;
        res = '0;
        for (int k = 0; k < quant_cfg_pkg::NUM_COEF; k++) begin
            q = (k == 0) ? int'(quant_cfg_pkg::DC_BASE_Q[r.qidx]) :
                           int'(quant_cfg_pkg::AC_BASE_Q[r.qidx]);
            if (r.btype == quant_cfg_pkg::BT_CHROMA) begin
                q    = (q / 2 < 2) ? 2 : q / 2;
                bias = (k == 0) ? 110 : 115;
                shp  = 0;
            end else begin
                bias = (k == 0) ? 96 : 110;
                shp  = (k == 0) ? 0 : int'(quant_cfg_pkg::SHARPEN_TAB[k]) * q / 2048;
            end
            bias   = bias * 512;
            iq     = 131072 / q;
            zth    = (131071 - bias) / iq;
            v      = int'(r.blk[k]);
            coeff  = ((v < 0) ? -v : v) + shp;
            scaled = (longint'(coeff) * iq + bias) >>> quant_cfg_pkg::QFIX;
            lvl    = (scaled > quant_cfg_pkg::MAX_LEVEL) ? quant_cfg_pkg::MAX_LEVEL : int'(scaled);
            if (coeff <= zth) begin
                lvl = 0;
            end
            if (v < 0) begin
                lvl = -lvl;
            end
            lv[k]        = 16'(lvl);
            res.recon[k] = 16'(lvl * q);
            res.nz       = res.nz | (lvl != 0);
        end
        for (int z = 0; z < quant_cfg_pkg::NUM_COEF; z++) begin
            res.levels[z] = lv[quant_data_pkg::ZIGZAG[z]];
        end
        return res;
    endfunction

    task automatic compare_block(input string name, input quant_data_pkg::coef_block_t got,
                                 input quant_data_pkg::coef_block_t want);
        for (int k = 0; k < quant_cfg_pkg::NUM_COEF; k++) begin
            if (got[k] !== want[k]) begin
                stop_with_error($sformatf("MISMATCH time %0t %s[%0d] got %0d expected %0d",
                                          $time, name, k, got[k], want[k]));
            end
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            stop_with_error($sformatf("MISMATCH time %0t %s got %b expected %b",
                                      $time, name, got, want));
        end
    endtask

    // Mode 0 spread magnitudes, 1 near full scale, 2 small values
    task automatic make_block(input int mode, output quant_data_pkg::coef_block_t blk);
        logic signed [15:0] v;
        int unsigned        sh;
        for (int k = 0; k < quant_cfg_pkg::NUM_COEF; k++) begin
            if (mode == 0) begin
                v      = 16'(lfsr_bits(drv_lfsr, 16));
                sh     = lfsr_bits(drv_lfsr, 4);
                blk[k] = v >>> sh;
            end else if (mode == 1) begin
                blk[k] = NEAR_FULL[lfsr_bits(drv_lfsr, 2)];
            end else begin
                v      = 16'(lfsr_bits(drv_lfsr, 3));
                blk[k] = (lfsr_bits(drv_lfsr, 1) != 0) ? -v : v;
            end
        end
    endtask

    // One full four-phase transfer on the input link
    task automatic send_block(input quant_data_pkg::quant_req_t r,
                              input quant_data_pkg::quant_res_t e);
        in_data <= r;
        in_req  <= 1'b1;
        do @(posedge clk); while (!in_ack);
        exp_q.push_back(e);
        in_req <= 1'b0;
        do @(posedge clk); while (in_ack);
    endtask

    task automatic run_case(input int qi, input int bt, input int mode);
        quant_data_pkg::quant_req_t r;
        quant_data_pkg::quant_res_t e;
        r.qidx  = 3'(qi);
        r.btype = quant_cfg_pkg::block_type_e'(bt);
        make_block(mode, r.blk);
        e = ref_quant(r);
        if (mode == 2 && e.nz) begin
            stop_with_error("Small-coefficient block is not under the zero threshold");
        end
        send_block(r, e);
    endtask

    //--------------------------------------
    // Stimulus
    //--------------------------------------
    initial begin : run_tests
        quant_data_pkg::quant_req_t zero_req;
        in_req   = 1'b0;
        in_data  = '0;
        zero_req = '0;
        do @(posedge clk); while (!rst_n);
        compare_bit("in_ack_o", in_ack, 1'b0);
        compare_bit("out_req_o", out_req, 1'b0);
        send_block(zero_req, ref_quant(zero_req));
        for (int qi = 0; qi < 8; qi++) begin
            for (int bt = 0; bt < 2; bt++) begin
                for (int n = 0; n < RAND_PER_CASE; n++) begin
                    run_case(qi, bt, 0);
                end
            end
        end
        // Saturation at the smallest steps
        for (int qi = 0; qi < 2; qi++) begin
            for (int bt = 0; bt < 2; bt++) begin
                run_case(qi, bt, 1);
            end
        end
        for (int qi = 4; qi < 8; qi++) begin
            for (int bt = 0; bt < 2; bt++) begin
                run_case(qi, bt, 2);
            end
        end
        while (n_checked < NUM_BLOCKS) @(posedge clk);
        if (n_checked == NUM_BLOCKS && exp_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_error($sformatf("%0d results checked but %0d blocks were sent",
                                      n_checked, NUM_BLOCKS));
        end
    end

    // Output link receiver with random ack delay
    initial begin : check_results
        quant_data_pkg::quant_res_t got;
        quant_data_pkg::quant_res_t want;
        int unsigned                delay;
        out_ack = 1'b0;
        forever begin
            do @(posedge clk); while (!out_req);
            got = out_data;
            if (exp_q.size() == 0) begin
                stop_with_error("A result was offered with no block outstanding");
            end
            want = exp_q.pop_front();
            compare_block("out_data_o.levels", got.levels, want.levels);
            compare_block("out_data_o.recon", got.recon, want.recon);
            compare_bit("out_data_o.nz", got.nz, want.nz);
            n_checked++;
            delay = lfsr_bits(ack_lfsr, 3);
            repeat (delay) @(posedge clk);
            out_ack <= 1'b1;
            do @(posedge clk); while (out_req);
            out_ack <= 1'b0;
        end
    end

    // One block outstanding from its in_ack until its out_ack falls
    initial begin : watch_backpressure
        logic ack_prev;
        logic oack_prev;
        logic holding;
        ack_prev  = 1'b0;
        oack_prev = 1'b0;
        holding   = 1'b0;
        forever begin
            @(posedge clk);
            if (in_ack && !ack_prev) begin
                if (holding) begin
                    stop_with_error("in_ack_o rose before the previous out_ack had fallen");
                end
                holding = 1'b1;
            end
            if (!out_ack && oack_prev) begin
                holding = 1'b0;
            end
            ack_prev  = in_ack;
            oack_prev = out_ack;
        end
    end

    initial begin : watchdog
        repeat (NUM_BLOCKS * CYCLES_PER_BLOCK) @(posedge clk);
        stop_with_error($sformatf("Timeout: only %0d of %0d results arrived in time",
                                  n_checked, NUM_BLOCKS));
    end

endmodule
